//--- src.f
sd_init_pkg.sv
sd_clock_divider.sv
sd_cmd_serializer.sv
sd_init_sequencer.sv
sd_init_top.sv
tb_sd_checker.sv
tb_sd_init.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the SD init testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_sd_init
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_sd_init)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

//--- tb_sd_init.sv
// ---------------------------------------------------------------------------
// SD init testbench: clock, reset, random reset injection over four runs,
// DUT and checker instances and the final report
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_sd_init
    import sd_init_pkg::*;
();

    logic         clk_sys;
    logic         reset_n_sys;
    logic         sd_clk;
    logic         sd_cmd_out;
    logic         sd_cmd_oe;
    status_char_t status_char;
    logic         status_valid;
    logic         init_done;
    int           error_count;
    int           bit_count;
    int           char_count;

    sd_init_top uut (
        .clk_sys      (clk_sys),
        .reset_n_sys  (reset_n_sys),
        .sd_clk       (sd_clk),
        .sd_cmd_out   (sd_cmd_out),
        .sd_cmd_oe    (sd_cmd_oe),
        .status_char  (status_char),
        .status_valid (status_valid),
        .init_done    (init_done)
    );

    tb_sd_checker u_checker (
        .clk_sys      (clk_sys),
        .reset_n_sys  (reset_n_sys),
        .sd_clk       (sd_clk),
        .sd_cmd_out   (sd_cmd_out),
        .sd_cmd_oe    (sd_cmd_oe),
        .status_char  (status_char),
        .status_valid (status_valid),
        .init_done    (init_done),
        .error_count  (error_count),
        .bit_count    (bit_count),
        .char_count   (char_count)
    );

    // 4 ns clk_sys
    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic run_cycles(input int count);
        for (int i = 0; i < count; i++) @(posedge clk_sys);
    endtask

    // inputs move 1 ns after the rising edge
    task automatic pulse_reset(input int cycles);
        @(posedge clk_sys);
        #1 reset_n_sys = 1'b0;
        run_cycles(cycles);
        #1 reset_n_sys = 1'b1;
    endtask

    task automatic wait_init_done(input int limit, output bit timed_out);
        int n;
        n = 0;
        while (init_done !== 1'b1 && n < limit) begin
            @(posedge clk_sys);
            #1 n++;
        end
        timed_out = (init_done !== 1'b1);
    endtask

    initial begin
        logic [31:0] rng_state;
        int          seq_cycles, stream_bits, run, hold, cut_cycle;
        int          injected, start_errors, run_errors;
        bit          cut, timed_out;
        reset_n_sys  = 1'b0;
        rng_state    = 32'h4a07_ecc0;
        injected     = 0;
        run_errors   = 0;
        timed_out    = 1'b0;
        stream_bits  = IDLE_BITS + NUM_CMDS * FRAME_BITS;
        // first sd_clk period, idle bits, three frames and their gaps
        seq_cycles   = (1 + IDLE_BITS + NUM_CMDS * (FRAME_BITS + GAP_BITS)) * 2 * SD_CLK_HALF_CYCLES;
        // four runs
        for (run = 0; run < 4 && !timed_out; run++) begin
            rng_state = xorshift32(rng_state);
            hold = (run == 0) ? 8 : 1 + int'(rng_state % 32'd8);
            pulse_reset(hold);
            start_errors = error_count;
            rng_state = xorshift32(rng_state);
            // last run always completes, so the restarted stream is checked
            cut = (run < 3) && (rng_state[0] || (run == 2 && injected == 0));
            if (cut) begin
                rng_state = xorshift32(rng_state);
                cut_cycle = 1 + int'(rng_state % 32'(seq_cycles));
                run_cycles(cut_cycle);
                injected++;
                $display("run %0d: reset injected after %0d cycles, %0d bits, %0d errors",
                         run, cut_cycle, bit_count, error_count - start_errors);
            end else begin
                wait_init_done(seq_cycles + 8 * SD_CLK_HALF_CYCLES, timed_out);
                if (timed_out) begin
                    $display("run %0d: timeout, init_done never rose", run);
                end else begin
                    // a few more bits with the line parked
                    run_cycles(12 * SD_CLK_HALF_CYCLES);
                    if (bit_count != stream_bits) begin
                        $display("[ERROR] run_%0d bit_count expected %0d actual %0d",
                                 run, stream_bits, bit_count);
                        run_errors++;
                    end
                    if (char_count != NUM_CMDS + 1) begin
                        $display("[ERROR] run_%0d char_count expected %0d actual %0d",
                                 run, NUM_CMDS + 1, char_count);
                        run_errors++;
                    end
                    $display("run %0d: complete, %0d bits, %0d characters, %0d errors",
                             run, bit_count, char_count, error_count - start_errors);
                end
            end
        end
        $display("summary: %0d runs, %0d resets injected, %0d errors",
                 run, injected, error_count + run_errors);
        if (timed_out || error_count + run_errors != 0) begin
            $display("TB FAILED");
        end else begin
            $display("TB PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_sd_checker.sv
// ---------------------------------------------------------------------------
// SD init checker: rebuilds the expected command line stream and status
// character order from the DUT ports and counts mismatches
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_sd_checker
    import sd_init_pkg::*;
(
    input  logic         clk_sys,
    input  logic         reset_n_sys,
    input  logic         sd_clk,
    input  logic         sd_cmd_out,
    input  logic         sd_cmd_oe,
    input  status_char_t status_char,
    input  logic         status_valid,
    input  logic         init_done,
    output int           error_count,
    output int           bit_count,
    output int           char_count
);

    int   errors = 0;
    int   bits = 0;
    int   chars = 0;
    // released-line rising edges since the last frame
    int   gap_edges = 0;
    // clk_sys cycles since the last sd_clk edge
    int   since_edge = 0;
    logic seen_edge = 1'b0;
    // samples after reset release still held to the reset state
    int   settle_left = 0;
    logic prev_clk = 1'b0;
    logic prev_out = 1'b1;
    logic prev_oe = 1'b0;
    logic prev_done = 1'b0;
    int   stream_bits = IDLE_BITS + NUM_CMDS * FRAME_BITS;

    assign error_count = errors;
    assign bit_count   = bits;
    assign char_count  = chars;

    // idle ones, then each frame msb first
    function automatic logic expected_bit(input int idx);
        sd_frame_t f;
        int        pos;
        if (idx < IDLE_BITS) begin
            return 1'b1;
        end
        pos = idx - IDLE_BITS;
        case (pos / FRAME_BITS)
            0:       f = CMD0_FRAME;
            1:       f = CMD55_FRAME;
            default: f = ACMD41_FRAME;
        endcase
        f = f >> (FRAME_BITS - 1 - pos % FRAME_BITS);
        return f[0];
    endfunction

    function automatic status_char_t expected_char(input int idx);
        case (idx)
            0:       return CHAR_CMD0;
            1:       return CHAR_CMD55;
            2:       return CHAR_ACMD41;
            default: return CHAR_DONE;
        endcase
    endfunction

    task automatic log_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // sampled mid-cycle, away from the clk_sys rising edge
    always @(negedge clk_sys) begin
        int exp_bits;
        // reset, the release cycle and the first clocked cycle: all outputs inactive
        if (!reset_n_sys || settle_left != 0) begin
            if (sd_clk || sd_cmd_oe || !sd_cmd_out || status_valid || init_done)
                log_error($sformatf(
                    "[ERROR] reset_state clk/oe/out/valid/done expected 00100 actual %b%b%b%b%b",
                    sd_clk, sd_cmd_oe, sd_cmd_out, status_valid, init_done));
        end
        if (!reset_n_sys) begin
            settle_left = 2;
        end else if (settle_left != 0) begin
            settle_left--;
        end
        if (!reset_n_sys) begin
            // model restarts from the first idle bit
            bits       = 0;
            chars      = 0;
            gap_edges  = 0;
            since_edge = 0;
            seen_edge  = 1'b0;
            prev_clk   = 1'b0;
            prev_out   = 1'b1;
            prev_oe    = 1'b0;
            prev_done  = 1'b0;
        end else begin
            since_edge++;
            if (sd_clk !== prev_clk) begin
                if (seen_edge && since_edge != SD_CLK_HALF_CYCLES)
                    log_error($sformatf("[ERROR] sd_clk_half_period expected %0d actual %0d",
                                        SD_CLK_HALF_CYCLES, since_edge));
                since_edge = 0;
                seen_edge  = 1'b1;
            end
            // rising edge, card samples the line here
            if (sd_clk && !prev_clk) begin
                if (sd_cmd_out !== prev_out || sd_cmd_oe !== prev_oe)
                    log_error("command line changed in the same cycle as an sd_clk rising edge");
                if (!sd_cmd_oe) begin
                    if (bits > IDLE_BITS) gap_edges++;
                end else begin
                    // start of CMD55 or ACMD41 closes a gap
                    if (bits > IDLE_BITS && bits < stream_bits
                        && (bits - IDLE_BITS) % FRAME_BITS == 0) begin
                        if (gap_edges != GAP_BITS)
                            log_error($sformatf("[ERROR] gap_before_bit %0d expected %0d actual %0d",
                                                bits, GAP_BITS, gap_edges));
                        gap_edges = 0;
                    end
                    if (bits >= stream_bits)
                        log_error("command line driven after the end of the command stream");
                    else if (sd_cmd_out !== expected_bit(bits))
                        log_error($sformatf("[ERROR] cmd_stream bit %0d expected %0b actual %0b",
                                            bits, expected_bit(bits), sd_cmd_out));
                    bits++;
                end
            end
            if (status_valid) begin
                // each report follows the last bit of its frame
                exp_bits = (chars < NUM_CMDS) ? IDLE_BITS + FRAME_BITS * (chars + 1) : stream_bits;
                if (chars > NUM_CMDS) begin
                    log_error($sformatf("status pulse with '%c' after the last report", status_char));
                end else begin
                    if (status_char !== expected_char(chars))
                        log_error($sformatf("[ERROR] status_char %0d expected %c actual %c",
                                            chars, expected_char(chars), status_char));
                    if (bits != exp_bits)
                        log_error($sformatf(
                            "[ERROR] status_position %0d expected %0d bits actual %0d",
                            chars, exp_bits, bits));
                    if ((chars == NUM_CMDS) !== init_done)
                        log_error($sformatf("[ERROR] init_done_at_status %0d expected %0b actual %0b",
                                            chars, chars == NUM_CMDS, init_done));
                end
                chars++;
            end
            // done is sticky and parks the line
            if (init_done && !prev_done && !(status_valid && status_char == CHAR_DONE))
                log_error("init_done rose without the done character");
            if (prev_done && !init_done)
                log_error("init_done fell while out of reset");
            if (prev_done && sd_cmd_oe)
                log_error("sd_cmd_oe driven after init_done");
            prev_clk  = sd_clk;
            prev_out  = sd_cmd_out;
            prev_oe   = sd_cmd_oe;
            prev_done = init_done;
        end
    end

endmodule

`default_nettype wire

//--- sd_init_top.sv
// ---------------------------------------------------------------------------
// SD init top: clock divider, command serializer and init sequencer
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sd_init_top
    import sd_init_pkg::*;
(
    input  logic         clk_sys,
    input  logic         reset_n_sys,
    output logic         sd_clk,
    output logic         sd_cmd_out,
    output logic         sd_cmd_oe,
    output status_char_t status_char,
    output logic         status_valid,
    output logic         init_done
);

    // one pulse per sd bit
    logic      bit_tick;
    // sequencer to serializer
    sd_frame_t frame;
    logic      frame_load;
    // serializer back to sequencer
    logic      ser_bit;
    logic      frame_done;

    sd_clock_divider u_clock_divider (
        .clk_sys     (clk_sys),
        .reset_n_sys (reset_n_sys),
        .sd_clk      (sd_clk),
        .bit_tick    (bit_tick)
    );

    sd_cmd_serializer u_cmd_serializer (
        .clk_sys     (clk_sys),
        .reset_n_sys (reset_n_sys),
        .bit_tick    (bit_tick),
        .frame       (frame),
        .frame_load  (frame_load),
        .ser_bit     (ser_bit),
        .frame_done  (frame_done)
    );

    sd_init_sequencer u_init_sequencer (
        .clk_sys      (clk_sys),
        .reset_n_sys  (reset_n_sys),
        .bit_tick     (bit_tick),
        .ser_bit      (ser_bit),
        .frame_done   (frame_done),
        .frame        (frame),
        .frame_load   (frame_load),
        .sd_cmd_out   (sd_cmd_out),
        .sd_cmd_oe    (sd_cmd_oe),
        .status_char  (status_char),
        .status_valid (status_valid),
        .init_done    (init_done)
    );

endmodule

`default_nettype wire

//--- sd_init_sequencer.sv
// ---------------------------------------------------------------------------
// SD init sequencer: idle clocks, CMD0 / CMD55 / ACMD41 with gaps,
// status characters per command and a sticky done level
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sd_init_sequencer
    import sd_init_pkg::*;
(
    input  logic         clk_sys,
    input  logic         reset_n_sys,
    input  logic         bit_tick,
    input  logic         ser_bit,
    input  logic         frame_done,
    output sd_frame_t    frame,
    output logic         frame_load,
    output logic         sd_cmd_out,
    output logic         sd_cmd_oe,
    output status_char_t status_char,
    output logic         status_valid,
    output logic         init_done
);

    init_state_t state;
    // 0..2 select a command, 3 is the final done report
    logic [1:0]  cmd_idx;
    bit_count_t  bit_cnt;
    logic        idle_last;
    logic        gap_last;

    // idle: 0 means not started yet, n is the bit in progress
    assign idle_last = (state == S_IDLE_CLOCKS) && (bit_cnt == bit_count_t'(IDLE_BITS));
    // gap: report already sent, waiting for the tick that ends the gap
    assign gap_last  = (state == S_GAP) && (bit_cnt == bit_count_t'(GAP_BITS));

    // serializer is idle in both cases
    assign frame_load = bit_tick && (idle_last || gap_last);

    // frame and report character for the current command
    always_comb begin
        case (cmd_idx)
            2'd0: begin
                frame       = CMD0_FRAME;
                status_char = CHAR_CMD0;
            end
            2'd1: begin
                frame       = CMD55_FRAME;
                status_char = CHAR_CMD55;
            end
            2'd2: begin
                frame       = ACMD41_FRAME;
                status_char = CHAR_ACMD41;
            end
            default: begin
                frame       = ACMD41_FRAME;
                status_char = CHAR_DONE;
            end
        endcase
    end

    // line mux
    // high while idling, serializer during a frame, released otherwise
    assign sd_cmd_oe  = ((state == S_IDLE_CLOCKS) && (bit_cnt != '0)) || (state == S_FRAME);
    assign sd_cmd_out = (state == S_FRAME) ? ser_bit : 1'b1;

    assign status_valid = (state == S_REPORT);
    // rises with the 'D' strobe
    assign init_done    = ((state == S_REPORT) && (cmd_idx == 2'(NUM_CMDS)))
                          || (state == S_DONE);

    always_ff @(posedge clk_sys or negedge reset_n_sys) begin
        if (!reset_n_sys) begin
            state   <= S_IDLE_CLOCKS;
            cmd_idx <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                S_IDLE_CLOCKS: begin
                    // first tick starts bit 1, later ticks end one bit each
                    if (bit_tick) begin
                        if (idle_last) begin
                            state <= S_FRAME;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                S_FRAME: begin
                    // done tick counts as the first gap tick
                    if (frame_done) begin
                        state   <= S_GAP;
                        bit_cnt <= 8'd1;
                    end
                end
                S_GAP: begin
                    if (bit_tick) begin
                        if (gap_last) begin
                            state <= S_FRAME;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            // report just before the tick that closes the gap
                            if (bit_cnt == bit_count_t'(GAP_BITS - 1)) begin
                                state <= S_REPORT;
                            end
                        end
                    end
                end
                S_REPORT: begin
                    // one cycle per character
                    if (cmd_idx == 2'(NUM_CMDS)) begin
                        state <= S_DONE;
                    end else if (cmd_idx == 2'(NUM_CMDS - 1)) begin
                        // last command, 'D' goes out next cycle
                        cmd_idx <= cmd_idx + 1'b1;
                    end else begin
                        cmd_idx <= cmd_idx + 1'b1;
                        state   <= S_GAP;
                    end
                end
                S_DONE: begin
                    // parked until reset
                    state <= S_DONE;
                end
                default: begin
                    state <= S_IDLE_CLOCKS;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sd_cmd_serializer.sv
// ---------------------------------------------------------------------------
// SD command serializer: loads one 48-bit frame and shifts it out
// msb first, one bit per bit tick
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_serializer
    import sd_init_pkg::*;
(
    input  logic      clk_sys,
    input  logic      reset_n_sys,
    input  logic      bit_tick,
    input  sd_frame_t frame,
    input  logic      frame_load,
    output logic      ser_bit,
    output logic      frame_done
);

    sd_frame_t  shift_reg;
    bit_count_t bit_cnt;
    logic       busy;
    logic       last_bit;

    // bit currently on the line
    assign ser_bit = shift_reg[FRAME_BITS-1];

    assign last_bit = (bit_cnt == bit_count_t'(FRAME_BITS - 1));

    // tick that ends bit 47
    assign frame_done = busy && bit_tick && last_bit;

    // control state
    always_ff @(posedge clk_sys or negedge reset_n_sys) begin
        if (!reset_n_sys) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (frame_load) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end else if (busy && bit_tick) begin
            if (last_bit) begin
                // idle until the sequencer loads again
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // payload shifter
    // vacated positions fill with ones, the idle level of the line
    always_ff @(posedge clk_sys) begin
        if (frame_load) begin
            shift_reg <= frame;
        end else if (busy && bit_tick) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b1};
        end
    end

endmodule

`default_nettype wire

//--- sd_clock_divider.sv
// ---------------------------------------------------------------------------
// SD clock divider: slow sd_clk from clk_sys plus a one-cycle bit tick
// ahead of every falling edge
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sd_clock_divider
    import sd_init_pkg::*;
(
    input  logic clk_sys,
    input  logic reset_n_sys,
    output logic sd_clk,
    output logic bit_tick
);

    div_count_t div_count;
    logic       half_done;

    // last cycle of the current half period
    assign half_done = (div_count == div_count_t'(SD_CLK_HALF_CYCLES - 1));

    // tick in the cycle that drives sd_clk from high to low,
    // so the rest of the design updates together with the falling edge
    assign bit_tick = half_done && sd_clk;

    always_ff @(posedge clk_sys or negedge reset_n_sys) begin
        if (!reset_n_sys) begin
            div_count <= '0;
            // clock idles low out of reset
            sd_clk    <= 1'b0;
        end else if (half_done) begin
            div_count <= '0;
            sd_clk    <= ~sd_clk;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- sd_init_pkg.sv
// ---------------------------------------------------------------------------
// SD init package: timing constants, command frames, status characters,
// shared vector types and the sequencer state encoding
// ---------------------------------------------------------------------------
`default_nettype none

package sd_init_pkg;

    // clk_sys cycles per sd_clk half period, full bit is twice this
    localparam int SD_CLK_HALF_CYCLES = 250;
    localparam int DIV_COUNT_W        = $clog2(SD_CLK_HALF_CYCLES + 1);

    // phase lengths in sd_clk bits
    localparam int IDLE_BITS  = 80;
    localparam int GAP_BITS   = 16;
    localparam int FRAME_BITS = 48;

    // commands in the power-up sequence
    localparam int NUM_CMDS = 3;

    typedef logic [FRAME_BITS-1:0]  sd_frame_t;
    typedef logic [7:0]             status_char_t;
    typedef logic [DIV_COUNT_W-1:0] div_count_t;
    typedef logic [7:0]             bit_count_t;

    // start bit, tx bit, index, argument, crc7 and end bit
    localparam sd_frame_t CMD0_FRAME   = 48'h40_00_00_00_00_95;
    localparam sd_frame_t CMD55_FRAME  = 48'h77_00_00_00_00_65;
    // hcs set in the argument
    localparam sd_frame_t ACMD41_FRAME = 48'h69_40_00_00_00_77;

    // ascii report characters
    localparam status_char_t CHAR_CMD0   = "0";
    localparam status_char_t CHAR_CMD55  = "5";
    localparam status_char_t CHAR_ACMD41 = "A";
    localparam status_char_t CHAR_DONE   = "D";

    typedef enum logic [2:0] {
        S_IDLE_CLOCKS,
        S_FRAME,
        S_GAP,
        S_REPORT,
        S_DONE
    } init_state_t;

endpackage

`default_nettype wire
